// File: bench/hazard_cases.txt
# one line per cycle: inst_valid inst(hex) stall issue ex_load mem_load store_load
# the source holds inst while stall is high, so stalled lines repeat the instruction
# independent ops right after reset: addi x1, addi x2, add x3,x1,x2
1 00500093 0 1 0 0 0
1 00700113 0 1 0 0 0
1 002081B3 0 1 0 0 0
# ld x5,8(x10) then addi x6,x5,1
1 00853283 0 1 0 0 0
1 00128313 1 0 1 0 0
1 00128313 1 0 0 1 0
1 00128313 0 1 0 0 0
# ld x7,0(x11) then add x8,x3,x7 through rs2
1 0005B383 0 1 0 0 0
1 00718433 1 0 1 0 0
1 00718433 1 0 0 1 0
1 00718433 0 1 0 0 0
# ld x9, one independent op, then addi x14,x9,2
1 01063483 0 1 0 0 0
1 00300693 0 1 0 0 0
1 00248713 1 0 0 1 0
1 00248713 0 1 0 0 0
# ld x0 then add x15,x0,x0 twice, x0 never waits
1 00053003 0 1 0 0 0
1 000007B3 0 1 0 0 0
1 000007B3 0 1 0 0 0
# ld x16 then addi x17,x1,16 whose imm bits look like rs2 = x16
1 00053803 0 1 0 0 0
1 01008893 0 1 0 0 0
1 01008893 0 1 0 0 0
# sd x20,24(x10) then ld x21,24(x10)
1 01453C23 0 1 0 0 0
1 01853A83 1 0 0 0 1
1 01853A83 0 1 0 0 0
# sd at offset 32 then ld at offset 40
1 03453023 0 1 0 0 0
1 02853B03 0 1 0 0 0
# sd x20,48(x10), a bubble, then ld x23,48(x10)
1 03453823 0 1 0 0 0
0 03053B83 0 0 0 0 0
1 03053B83 0 1 0 0 0
# ld x24, dependent addi held invalid for a cycle
1 00053C03 0 1 0 0 0
0 000C0C93 0 0 0 0 0
1 000C0C93 1 0 0 1 0
1 000C0C93 0 1 0 0 0
# invalid load word to x26 leaves only a bubble, add x27,x26,x26 issues
0 00053D03 0 0 0 0 0
1 01AD0DB3 0 1 0 0 0
# one EX slot holds a load or a store, so ex_load wins over the alias check
1 00053E03 0 1 0 0 0
1 018E3E83 1 0 1 0 0
1 018E3E83 1 0 0 1 0
1 018E3E83 0 1 0 0 0
1 00000013 0 1 0 0 0

// File: bench/hazard_top_tb.sv
`timescale 1ns/1ps

module hazard_top_tb;

    localparam int    clk_period   = 100;
    localparam int    drive_delay  = 5;   // after the rising edge
    localparam int    check_lead   = 5;   // before the next rising edge
    localparam int    reset_cycles = 3;
    localparam string cases_path   = "bench/hazard_cases.txt";

    logic        clk;
    logic        rst_n;
    logic        inst_valid;
    logic [31:0] inst;
    logic        stall;
    logic        issue;
    logic        ex_load_hazard;
    logic        mem_load_hazard;
    logic        store_load_hazard;

    // one entry per cycle from the cases file
    logic        case_valid[$];
    logic [31:0] case_inst[$];
    logic [4:0]  case_expect[$];  // stall, issue, ex, mem, store-load
    int          case_line[$];
    int          cur_line;
    bit          cases_loaded;

    hazard_top u_dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .inst_valid        (inst_valid),
        .inst              (inst),
        .stall             (stall),
        .issue             (issue),
        .ex_load_hazard    (ex_load_hazard),
        .mem_load_hazard   (mem_load_hazard),
        .store_load_hazard (store_load_hazard)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic stop_failed();
        $display("Result: FAILED");
        $fatal(1, "hazard_top_tb stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s = 0x%0h, expected 0x%0h (cases line %0d)",
                     name, actual, expected, cur_line);
            stop_failed();
        end
    endtask

    // skips comment lines, keeps file line numbers for error lines
    task automatic load_cases();
        int          fd;
        int          line_no;
        int          fields;
        int          v_valid;
        int          v_stall;
        int          v_issue;
        int          v_ex;
        int          v_mem;
        int          v_sl;
        logic [31:0] v_inst;
        string       text;
        fd = $fopen(cases_path, "r");
        if (fd == 0) begin
            $display("cannot open %s for reading", cases_path);
            stop_failed();
        end else begin
            line_no = 0;
            while ($fgets(text, fd) != 0) begin
                line_no++;
                if (text.len() > 1 && text.substr(0, 0) != "#") begin
                    fields = $sscanf(text, "%d %h %d %d %d %d %d", v_valid, v_inst,
                                     v_stall, v_issue, v_ex, v_mem, v_sl);
                    if (fields != 7) begin
                        $display("line %0d of %s does not hold seven fields",
                                 line_no, cases_path);
                        stop_failed();
                    end else begin
                        case_valid.push_back(v_valid[0]);
                        case_inst.push_back(v_inst);
                        case_expect.push_back({v_stall[0], v_issue[0], v_ex[0],
                                               v_mem[0], v_sl[0]});
                        case_line.push_back(line_no);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_cases();
        for (int i = 0; i < case_inst.size(); i++) begin
            @(posedge clk);
            #(drive_delay);
            cur_line   = case_line[i];
            inst_valid = case_valid[i];
            inst       = case_inst[i];
            #(clk_period - drive_delay - check_lead);  // outputs settled here
            check_value("stall", 32'(stall), 32'(case_expect[i][4]));
            check_value("issue", 32'(issue), 32'(case_expect[i][3]));
            check_value("ex_load_hazard", 32'(ex_load_hazard), 32'(case_expect[i][2]));
            check_value("mem_load_hazard", 32'(mem_load_hazard), 32'(case_expect[i][1]));
            check_value("store_load_hazard", 32'(store_load_hazard),
                        32'(case_expect[i][0]));
        end
    endtask

    initial begin : watchdog
        int limit_cycles;
        wait (cases_loaded);
        limit_cycles = case_inst.size() + 10;  // reset and slack included
        #(limit_cycles * clk_period);
        $display("timeout: %0d cycles passed without the cases finishing", limit_cycles);
        stop_failed();
    end

    initial begin : stimulus
        rst_n        = 1'b0;
        inst_valid   = 1'b0;
        inst         = 32'h0000_0013;  // nop
        cur_line     = 0;
        cases_loaded = 1'b0;
        load_cases();
        if (case_inst.size() == 0) begin
            $display("%s holds no cases", cases_path);
            stop_failed();
        end else begin
            cases_loaded = 1'b1;
            repeat (reset_cycles) @(posedge clk);
            #(drive_delay);
            rst_n = 1'b1;
            run_cases();
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

// File: hdl/dest_track.sv
`timescale 1ns/1ps

module dest_track (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                issue,
    input  logic [hazard_pkg::reg_addr_w-1:0]   rd,
    input  logic                                is_load,
    input  logic                                is_store,
    input  logic [hazard_pkg::reg_addr_w-1:0]   rs1,
    input  logic [hazard_pkg::offset_w-1:0]     offset,
    output logic [hazard_pkg::reg_addr_w-1:0]   ex_rd,
    output logic                                ex_load,
    output logic                                ex_store,
    output logic [hazard_pkg::reg_addr_w-1:0]   ex_base,
    output logic [hazard_pkg::offset_w-1:0]     ex_offset,
    output logic [hazard_pkg::reg_addr_w-1:0]   mem_rd,
    output logic                                mem_load
);

    // slot control state, a bubble is rd 0 with both flags low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_rd    <= '0;
            ex_load  <= 1'b0;
            ex_store <= 1'b0;
            mem_rd   <= '0;
            mem_load <= 1'b0;
        end else begin
            if (issue) begin
                ex_rd    <= rd;
                ex_load  <= is_load;
                ex_store <= is_store;
            end else begin
                ex_rd    <= '0;  // bubble into EX
                ex_load  <= 1'b0;
                ex_store <= 1'b0;
            end
            mem_rd   <= ex_rd;   // EX always moves on to MEM
            mem_load <= ex_load;
        end
    end

    // store address key
    // only meaningful while ex_store is set
    always_ff @(posedge clk) begin
        ex_base   <= rs1;
        ex_offset <= offset;
    end

    // decode must never mark one instruction as both load and store
    a_slot_class: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(ex_load && ex_store)
    ) else $error("EX slot holds a load and a store at once");

endmodule

// File: hdl/hazard_pkg.sv
package hazard_pkg;

    localparam int reg_addr_w = 5;
    localparam int offset_w   = 12;

    // major opcodes, inst[6:0]
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_op     = 7'b0110011;
    localparam logic [6:0] op_op_imm = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;

    // I-type layout, loads and register-immediate ops
    typedef struct packed {
        logic [offset_w-1:0]   imm;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    // S-type layout, stores; rs2 also sits here for R-type
    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        logic [6:0]            opcode;
    } s_fmt_t;

    // one instruction word, read either way depending on opcode
    typedef union packed {
        i_fmt_t i_view;
        s_fmt_t s_view;
    } inst_word_u;

endpackage

// File: hdl/hazard_top.sv
`timescale 1ns/1ps

module hazard_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        inst_valid,
    input  logic [31:0] inst,
    output logic        stall,
    output logic        issue,
    output logic        ex_load_hazard,
    output logic        mem_load_hazard,
    output logic        store_load_hazard
);

    import hazard_pkg::*;

    // decoded ID fields
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    logic [offset_w-1:0]   offset;
    logic                  uses_rs2;
    logic                  is_load;
    logic                  is_store;

    // EX and MEM slot state
    logic [reg_addr_w-1:0] ex_rd;
    logic                  ex_load;
    logic                  ex_store;
    logic [reg_addr_w-1:0] ex_base;
    logic [offset_w-1:0]   ex_offset;
    logic [reg_addr_w-1:0] mem_rd;
    logic                  mem_load;

    assign issue = inst_valid & ~stall;  // leaves ID at this edge

    inst_fields u_fields (
        .inst     (inst),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .offset   (offset),
        .uses_rs2 (uses_rs2),
        .is_load  (is_load),
        .is_store (is_store)
    );

    dest_track u_track (
        .clk       (clk),
        .rst_n     (rst_n),
        .issue     (issue),
        .rd        (rd),
        .is_load   (is_load),
        .is_store  (is_store),
        .rs1       (rs1),
        .offset    (offset),
        .ex_rd     (ex_rd),
        .ex_load   (ex_load),
        .ex_store  (ex_store),
        .ex_base   (ex_base),
        .ex_offset (ex_offset),
        .mem_rd    (mem_rd),
        .mem_load  (mem_load)
    );

    id_hazard u_hazard (
        .clk               (clk),
        .rst_n             (rst_n),
        .inst_valid        (inst_valid),
        .rs1               (rs1),
        .rs2               (rs2),
        .uses_rs2          (uses_rs2),
        .is_load           (is_load),
        .offset            (offset),
        .ex_rd             (ex_rd),
        .ex_load           (ex_load),
        .ex_store          (ex_store),
        .ex_base           (ex_base),
        .ex_offset         (ex_offset),
        .mem_rd            (mem_rd),
        .mem_load          (mem_load),
        .stall             (stall),
        .ex_load_hazard    (ex_load_hazard),
        .mem_load_hazard   (mem_load_hazard),
        .store_load_hazard (store_load_hazard)
    );

endmodule

// File: hdl/id_hazard.sv
`timescale 1ns/1ps

module id_hazard (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                inst_valid,
    input  logic [hazard_pkg::reg_addr_w-1:0]   rs1,
    input  logic [hazard_pkg::reg_addr_w-1:0]   rs2,
    input  logic                                uses_rs2,
    input  logic                                is_load,
    input  logic [hazard_pkg::offset_w-1:0]     offset,
    input  logic [hazard_pkg::reg_addr_w-1:0]   ex_rd,
    input  logic                                ex_load,
    input  logic                                ex_store,
    input  logic [hazard_pkg::reg_addr_w-1:0]   ex_base,
    input  logic [hazard_pkg::offset_w-1:0]     ex_offset,
    input  logic [hazard_pkg::reg_addr_w-1:0]   mem_rd,
    input  logic                                mem_load,
    output logic                                stall,
    output logic                                ex_load_hazard,
    output logic                                mem_load_hazard,
    output logic                                store_load_hazard
);

    import hazard_pkg::*;

    logic ex_hit;
    logic mem_hit;
    logic alias_hit;

    // does the ID instruction read slot_rd; x0 never counts
    function automatic logic reads_reg(
        input logic [reg_addr_w-1:0] src1,
        input logic [reg_addr_w-1:0] src2,
        input logic                  src2_used,
        input logic [reg_addr_w-1:0] slot_rd
    );
        logic hit;
        hit = (src1 == slot_rd) || (src2_used && (src2 == slot_rd));
        return (slot_rd != '0) && hit;
    endfunction

    // load data is not forwarded from EX or MEM so the reader waits for WB
    assign ex_hit  = ex_load && reads_reg(rs1, rs2, uses_rs2, ex_rd);
    assign mem_hit = mem_load && reads_reg(rs1, rs2, uses_rs2, mem_rd);

    // same base register and offset means same address
    assign alias_hit = is_load && ex_store && (rs1 == ex_base) && (offset == ex_offset);

    always_comb begin
        ex_load_hazard    = 1'b0;
        mem_load_hazard   = 1'b0;
        store_load_hazard = 1'b0;
        if (inst_valid) begin
            if (ex_hit) begin
                ex_load_hazard = 1'b1;
            end else if (mem_hit) begin
                mem_load_hazard = 1'b1;
            end else if (alias_hit) begin
                store_load_hazard = 1'b1;
            end
        end
    end

    assign stall = ex_load_hazard | mem_load_hazard | store_load_hazard;

    // the store leaves EX and a bubble takes its place
    a_alias_once: assert property (
        @(posedge clk) disable iff (!rst_n)
        store_load_hazard |=> !store_load_hazard
    ) else $error("store-load hazard held for more than one cycle");

    // held instruction sees the load move from EX to MEM
    a_ex_then_mem: assert property (
        @(posedge clk) disable iff (!rst_n)
        ex_load_hazard |=> (!stall || mem_load_hazard)
    ) else $error("stall after EX load hazard has wrong cause");

endmodule

// File: hdl/inst_fields.sv
`timescale 1ns/1ps

module inst_fields (
    input  hazard_pkg::inst_word_u              inst,
    output logic [hazard_pkg::reg_addr_w-1:0]   rs1,
    output logic [hazard_pkg::reg_addr_w-1:0]   rs2,
    output logic [hazard_pkg::reg_addr_w-1:0]   rd,
    output logic [hazard_pkg::offset_w-1:0]     offset,
    output logic                                uses_rs2,
    output logic                                is_load,
    output logic                                is_store
);

    import hazard_pkg::*;

    logic [6:0] opcode;
    logic       is_op;
    logic       is_op_imm;
    logic       is_lui;
    logic       uses_rs1;
    logic       has_rd;

    assign opcode = inst.i_view.opcode;  // same bits in both views

    // funct3 111 is no load in RV64I, stores stop at sd
    assign is_load   = (opcode == op_load) && (inst.i_view.funct3 != 3'b111);
    assign is_store  = (opcode == op_store) && (inst.s_view.funct3[2] == 1'b0);
    assign is_op     = (opcode == op_op);
    assign is_op_imm = (opcode == op_op_imm);
    assign is_lui    = (opcode == op_lui);

    // lui keeps immediate bits where rs1 would be
    assign uses_rs1 = is_load | is_store | is_op | is_op_imm;

    // immediate forms hold imm bits in [24:20], never a register
    assign uses_rs2 = is_op | is_store;

    // stores put imm_lo in the rd field
    assign has_rd = is_load | is_op | is_op_imm | is_lui;

    assign rs1 = uses_rs1 ? inst.i_view.rs1 : '0;
    assign rs2 = inst.s_view.rs2;              // qualified by uses_rs2 downstream
    assign rd  = has_rd ? inst.i_view.rd : '0;

    // load offset from I view, store offset split over the S view
    always_comb begin
        if (is_store) begin
            offset = {inst.s_view.imm_hi, inst.s_view.imm_lo};
        end else begin
            offset = inst.i_view.imm;
        end
    end

endmodule

// File: id_hazard_unit.f
hdl/hazard_pkg.sv
hdl/inst_fields.sv
hdl/dest_track.sv
hdl/id_hazard.sv
hdl/hazard_top.sv
bench/hazard_top_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds and runs the hazard checker testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module hazard_top_tb \
    -f id_hazard_unit.f \
    -o hazard_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/hazard_sim)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Result: PASSED"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
